// File: include/afu_consts.svh
`ifndef AFU_CONSTS_SVH
`define AFU_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Host tag space
////////////////////////////////////////////////////////////////////////////

// Tags the host can have in flight
`define AFU_NUM_TAGS 8
`define AFU_TAG_W 3

////////////////////////////////////////////////////////////////////////////
// Credits and queues
////////////////////////////////////////////////////////////////////////////

// Credits the host grants out of reset
`define AFU_INIT_CREDITS 4
// Counter and credit return field share this width
`define AFU_CREDIT_W 4
// Entries per client command queue
`define AFU_CMD_DEPTH 4

// Field widths
`define AFU_ADDR_W 64
`define AFU_CU_W 8

`endif

// File: hdl/afu_pkg.sv
`include "afu_consts.svh"

package afu_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////////////////////

	// Host command opcodes
	typedef enum logic [1:0] {
		CMD_READ  = 2'd0,
		CMD_WRITE = 2'd1
	} cmd_op_e;

	// Host response codes, passed through to the clients
	typedef enum logic [1:0] {
		RSP_DONE   = 2'd0,
		RSP_FAULT  = 2'd1,
		RSP_FAILED = 2'd2
	} rsp_code_e;

	////////////////////////////////////////////////////////////////////////////
	// Command and response lines
	////////////////////////////////////////////////////////////////////////////

	// Client command, opcode implied by the queue it goes into
	typedef struct packed {
		logic [`AFU_CU_W-1:0]   cu_id;
		logic [`AFU_ADDR_W-1:0] addr;
	} client_cmd_t;

	// Command towards the host
	typedef struct packed {
		logic                   valid;
		cmd_op_e                opcode;
		logic [`AFU_TAG_W-1:0]  tag;
		logic [`AFU_ADDR_W-1:0] addr;
	} host_cmd_t;

	// Response from the host
	// Credits field returns to the issue counter
	typedef struct packed {
		logic                    valid;
		logic [`AFU_TAG_W-1:0]   tag;
		rsp_code_e               code;
		logic [`AFU_CREDIT_W-1:0] credits;
	} host_rsp_t;

	// Response routed back to a client
	typedef struct packed {
		logic                 valid;
		logic [`AFU_CU_W-1:0] cu_id;
		rsp_code_e            code;
	} client_rsp_t;

endpackage

// File: hdl/cmd_queue.sv
`include "afu_consts.svh"

module cmd_queue import afu_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  client_cmd_t in_cmd,
	input  logic        in_valid,
	output logic        in_ready,
	output client_cmd_t head_cmd,
	output logic        not_empty,
	input  logic        pop
);

	localparam int DEPTH = `AFU_CMD_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Entry storage
	client_cmd_t      mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	// Occupancy, 0 to DEPTH
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop_ok;

	// Wrap at the last entry
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Handshake and status
	////////////////////////////////////////////////////////////////////////////

	// Ready whenever a slot is free
	assign in_ready  = (count != CNT_W'(DEPTH));
	assign not_empty = (count != '0);
	assign push      = in_valid && in_ready;
	// Stray pop on an empty queue is ignored
	assign pop_ok    = pop && not_empty;

	// Head is read straight out of storage
	assign head_cmd = mem[rd_ptr];

	////////////////////////////////////////////////////////////////////////////
	// Storage and pointers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= in_cmd;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop_ok) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// Push with pop leaves the count alone
			unique case ({push, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: hdl/cmd_issue.sv
`include "afu_consts.svh"

module cmd_issue import afu_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  client_cmd_t rd_head,
	input  client_cmd_t wr_head,
	input  logic        rd_not_empty,
	input  logic        wr_not_empty,
	output logic        rd_pop,
	output logic        wr_pop,
	output host_cmd_t   host_cmd,
	input  host_rsp_t   host_rsp,
	output client_rsp_t read_rsp,
	output client_rsp_t write_rsp
);

	localparam int NUM_TAGS = `AFU_NUM_TAGS;
	localparam int TAG_W    = `AFU_TAG_W;
	localparam int CREDIT_W = `AFU_CREDIT_W;

	// Latched host response
	host_rsp_t           rsp_q;

	// Credit tracking
	logic [CREDIT_W-1:0] credit_cnt;
	logic [CREDIT_W-1:0] credit_next;
	logic                credit_avail;

	// Tag tracking, one busy bit per tag
	logic [NUM_TAGS-1:0] tag_busy;
	logic [NUM_TAGS-1:0] tag_busy_next;
	logic [TAG_W-1:0]    free_tag;
	logic                tag_avail;

	// Opcode and requester per tag
	cmd_op_e             tag_op [NUM_TAGS];
	logic [`AFU_CU_W-1:0] tag_cu [NUM_TAGS];
	cmd_op_e             rsp_op;

	// Arbitration result
	logic                issue_go;
	client_cmd_t         sel_cmd;
	cmd_op_e             sel_op;

	////////////////////////////////////////////////////////////////////////////
	// Host response latch
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rsp_q <= '0;
		end else begin
			rsp_q <= host_rsp;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Arbitration and issue
	////////////////////////////////////////////////////////////////////////////

	// Lowest free tag, scanned from the top so the low index wins
	always_comb begin
		free_tag = '0;
		for (int i = NUM_TAGS - 1; i >= 0; i--) begin
			if (!tag_busy[i]) begin
				free_tag = TAG_W'(i);
			end
		end
	end

	assign tag_avail    = ~&tag_busy;
	assign credit_avail = (credit_cnt != '0);

	// Fire needs work, a credit and a tag
	assign issue_go = (rd_not_empty || wr_not_empty) && credit_avail && tag_avail;

	// Write queue has priority over read
	assign sel_cmd = wr_not_empty ? wr_head : rd_head;
	assign sel_op  = wr_not_empty ? CMD_WRITE : CMD_READ;
	assign wr_pop  = issue_go && wr_not_empty;
	assign rd_pop  = issue_go && !wr_not_empty;

	// Host command registered on the pop edge
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			host_cmd <= '0;
		end else begin
			host_cmd.valid <= issue_go;
			if (issue_go) begin
				host_cmd.opcode <= sel_op;
				host_cmd.tag    <= free_tag;
				host_cmd.addr   <= sel_cmd.addr;
			end
		end
	end

	// Remember what each tag went out for
	always_ff @(posedge clock) begin
		if (issue_go) begin
			tag_op[free_tag] <= sel_op;
			tag_cu[free_tag] <= sel_cmd.cu_id;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Credits and tags
	////////////////////////////////////////////////////////////////////////////

	// Charge and refund may land on the same edge
	always_comb begin
		credit_next = credit_cnt;
		if (issue_go) begin
			credit_next = credit_next - 1'b1;
		end
		if (rsp_q.valid) begin
			credit_next = credit_next + rsp_q.credits;
		end
	end

	// Freed tag is busy, so it never collides with the issued one
	always_comb begin
		tag_busy_next = tag_busy;
		if (rsp_q.valid) begin
			tag_busy_next[rsp_q.tag] = 1'b0;
		end
		if (issue_go) begin
			tag_busy_next[free_tag] = 1'b1;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			credit_cnt <= CREDIT_W'(`AFU_INIT_CREDITS);
			tag_busy   <= '0;
		end else begin
			credit_cnt <= credit_next;
			tag_busy   <= tag_busy_next;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Response routing
	////////////////////////////////////////////////////////////////////////////

	// Side picked by the stored opcode
	assign rsp_op = tag_op[rsp_q.tag];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			read_rsp  <= '0;
			write_rsp <= '0;
		end else begin
			read_rsp.valid  <= rsp_q.valid && (rsp_op == CMD_READ);
			write_rsp.valid <= rsp_q.valid && (rsp_op == CMD_WRITE);
			// Same payload to both, valid tells which one counts
			read_rsp.cu_id  <= tag_cu[rsp_q.tag];
			read_rsp.code   <= rsp_q.code;
			write_rsp.cu_id <= tag_cu[rsp_q.tag];
			write_rsp.code  <= rsp_q.code;
		end
	end

endmodule

// File: hdl/afu_control.sv
module afu_control import afu_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  client_cmd_t rd_cmd,
	input  client_cmd_t wr_cmd,
	input  logic        rd_valid,
	input  logic        wr_valid,
	output logic        rd_ready,
	output logic        wr_ready,
	output host_cmd_t   host_cmd,
	input  host_rsp_t   host_rsp,
	output client_rsp_t read_rsp,
	output client_rsp_t write_rsp
);

	// Queue heads and pops
	client_cmd_t rd_head;
	client_cmd_t wr_head;
	logic        rd_not_empty;
	logic        wr_not_empty;
	logic        rd_pop;
	logic        wr_pop;

	////////////////////////////////////////////////////////////////////////////
	// Client command queues
	////////////////////////////////////////////////////////////////////////////

	// Read client
	cmd_queue read_queue (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_cmd    (rd_cmd),
		.in_valid  (rd_valid),
		.in_ready  (rd_ready),
		.head_cmd  (rd_head),
		.not_empty (rd_not_empty),
		.pop       (rd_pop)
	);

	// Write client
	cmd_queue write_queue (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_cmd    (wr_cmd),
		.in_valid  (wr_valid),
		.in_ready  (wr_ready),
		.head_cmd  (wr_head),
		.not_empty (wr_not_empty),
		.pop       (wr_pop)
	);

	////////////////////////////////////////////////////////////////////////////
	// Issue stage, credits, tags and response routing
	////////////////////////////////////////////////////////////////////////////

	cmd_issue issue (
		.clock        (clock),
		.rst_n        (rst_n),
		.rd_head      (rd_head),
		.wr_head      (wr_head),
		.rd_not_empty (rd_not_empty),
		.wr_not_empty (wr_not_empty),
		.rd_pop       (rd_pop),
		.wr_pop       (wr_pop),
		.host_cmd     (host_cmd),
		.host_rsp     (host_rsp),
		.read_rsp     (read_rsp),
		.write_rsp    (write_rsp)
	);

endmodule

// File: sim/afu_clock_gen.sv
module afu_clock_gen (
	output logic clock,
	output logic rst_n
);

	// Period of 8
	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Reset over two rising edges, released away from them
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
	end

endmodule

// File: sim/afu_control_properties.sv
`include "afu_consts.svh"

module afu_control_properties import afu_pkg::*; (
	input logic      clock,
	input logic      rst_n,
	input host_cmd_t host_cmd,
	input host_rsp_t host_rsp,
	input logic      rd_not_empty,
	input logic      wr_not_empty
);

	// Bus response delayed to the edge where the issue stage applies it
	host_rsp_t                rsp_d1;
	host_rsp_t                rsp_d2;
	// Credits and busy tags rebuilt from the host bus alone
	logic [`AFU_CREDIT_W-1:0] bus_credits;
	logic [`AFU_NUM_TAGS-1:0] bus_busy;

	////////////////////////////////////////////////////////////////////////////
	// Shadow state seen by the issue decision
	////////////////////////////////////////////////////////////////////////////

	// Lags the issue stage by one edge, matching host_cmd
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rsp_d1      <= '0;
			rsp_d2      <= '0;
			bus_credits <= `AFU_CREDIT_W'(`AFU_INIT_CREDITS);
			bus_busy    <= '0;
		end else begin
			rsp_d1      <= host_rsp;
			rsp_d2      <= rsp_d1;
			bus_credits <= bus_credits - `AFU_CREDIT_W'(host_cmd.valid)
				+ (rsp_d2.valid ? rsp_d2.credits : '0);
			if (rsp_d2.valid) begin
				bus_busy[rsp_d2.tag] <= 1'b0;
			end
			if (host_cmd.valid) begin
				bus_busy[host_cmd.tag] <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Credit and tag rules
	////////////////////////////////////////////////////////////////////////////

	credit_on_issue: assert property (@(posedge clock) disable iff (!rst_n)
		host_cmd.valid |-> bus_credits != '0)
		else $error("command issued with the credit count at zero");

	// Tag handed out must be idle
	tag_free_on_issue: assert property (@(posedge clock) disable iff (!rst_n)
		host_cmd.valid |-> !bus_busy[host_cmd.tag])
		else $error("command issued on a busy tag");

	////////////////////////////////////////////////////////////////////////////
	// Queue pops
	////////////////////////////////////////////////////////////////////////////

	rd_pop_not_empty: assert property (@(posedge clock) disable iff (!rst_n)
		host_cmd.valid && host_cmd.opcode == CMD_READ |-> $past(rd_not_empty))
		else $error("pop sent to an empty read queue");

	wr_pop_not_empty: assert property (@(posedge clock) disable iff (!rst_n)
		host_cmd.valid && host_cmd.opcode == CMD_WRITE |-> $past(wr_not_empty))
		else $error("pop sent to an empty write queue");

endmodule

bind cmd_issue afu_control_properties props_i (
	.clock        (clock),
	.rst_n        (rst_n),
	.host_cmd     (host_cmd),
	.host_rsp     (host_rsp),
	.rd_not_empty (rd_not_empty),
	.wr_not_empty (wr_not_empty)
);

// File: sim/afu_control_tb.sv
`include "afu_consts.svh"

module afu_control_tb import afu_pkg::*; ();

	localparam int N_RANDOM = 60;
	// Flood phase adds credits plus two full queues
	localparam int N_CMDS   = N_RANDOM + `AFU_INIT_CREDITS + 2 * `AFU_CMD_DEPTH;
	localparam int DEPTH    = `AFU_CMD_DEPTH;

	logic        clock;
	logic        rst_n;
	client_cmd_t rd_cmd = '0;
	client_cmd_t wr_cmd = '0;
	logic        rd_valid = 1'b0;
	logic        wr_valid = 1'b0;
	logic        rd_ready;
	logic        wr_ready;
	host_cmd_t   host_cmd;
	host_rsp_t   host_rsp = '0;
	client_rsp_t read_rsp;
	client_rsp_t write_rsp;

	// Phase flags, set by the sequencer
	logic running    = 1'b0;
	logic traffic_on = 1'b0;
	logic flood      = 1'b0;
	logic withhold   = 1'b0;

	logic [31:0] lfsr = 32'h92f1_6d67;

	// Accepted but not yet issued, per side
	client_cmd_t exp_rd [$];
	client_cmd_t exp_wr [$];
	// Tags the host still owes a response for
	logic [`AFU_TAG_W-1:0]    pending [$];
	cmd_op_e                  tag_op [`AFU_NUM_TAGS];
	logic [`AFU_CU_W-1:0]     tag_cu [`AFU_NUM_TAGS];
	logic [`AFU_NUM_TAGS-1:0] model_busy = '0;
	int                       model_credits = `AFU_INIT_CREDITS;
	// Response driven two falling edges back
	host_rsp_t                rsp_prev = '0;
	logic                     rd_ready_seen = 1'b0;
	logic                     wr_ready_seen = 1'b0;
	int                       accepted = 0;

	afu_clock_gen clock_gen (
		.clock (clock),
		.rst_n (rst_n)
	);

	afu_control afu_control_i (
		.clock     (clock),
		.rst_n     (rst_n),
		.rd_cmd    (rd_cmd),
		.wr_cmd    (wr_cmd),
		.rd_valid  (rd_valid),
		.wr_valid  (wr_valid),
		.rd_ready  (rd_ready),
		.wr_ready  (wr_ready),
		.host_cmd  (host_cmd),
		.host_rsp  (host_rsp),
		.read_rsp  (read_rsp),
		.write_rsp (write_rsp)
	);

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [63:0] lfsr_bits(input int n);
		logic [63:0] value;
		logic        fb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr  = {lfsr[30:0], fb};
			value = {value[62:0], fb};
		end
		return value;
	endfunction

	function automatic logic [`AFU_TAG_W-1:0] lowest_free(input logic [`AFU_NUM_TAGS-1:0] busy);
		for (int i = 0; i < `AFU_NUM_TAGS; i++) begin
			if (!busy[i]) begin
				return `AFU_TAG_W'(i);
			end
		end
		return '0;
	endfunction

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_host_cmd(input host_cmd_t exp, input host_cmd_t act);
		if (exp.valid !== act.valid || (exp.valid && exp !== act)) begin
			stop_on_error($sformatf("mismatch at %0t: host_cmd expected %h got %h",
				$time, exp, act));
		end
	endtask

	// Payload only counts while valid
	task automatic check_client_rsp(input string name, input client_rsp_t exp,
			input client_rsp_t act);
		if (exp.valid !== act.valid || (exp.valid && exp !== act)) begin
			stop_on_error($sformatf("mismatch at %0t: %s expected %h got %h",
				$time, name, exp, act));
		end
	endtask

	task automatic check_ready(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			stop_on_error($sformatf("mismatch at %0t: %s expected %b got %b",
				$time, name, exp, act));
		end
	endtask

	// Nothing queued, owed or held by a client
	task automatic wait_drained();
		while (exp_rd.size() > 0 || exp_wr.size() > 0 || pending.size() > 0 ||
				model_credits != `AFU_INIT_CREDITS || rd_valid || wr_valid) begin
			@(posedge clock);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Per-cycle model, checks and stimulus on the falling edge
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		host_cmd_t   exp_cmd;
		client_rsp_t exp_read;
		client_rsp_t exp_write;
		client_cmd_t entry;
		int          pick;
		if (running) begin
			// Issue decided on the previous cycle's state, write side first
			exp_cmd       = '0;
			exp_cmd.valid = (exp_rd.size() > 0 || exp_wr.size() > 0) &&
				model_credits > 0 && ~&model_busy;
			if (exp_cmd.valid) begin
				if (exp_wr.size() > 0) begin
					entry          = exp_wr.pop_front();
					exp_cmd.opcode = CMD_WRITE;
				end else begin
					entry          = exp_rd.pop_front();
					exp_cmd.opcode = CMD_READ;
				end
				exp_cmd.tag             = lowest_free(model_busy);
				exp_cmd.addr            = entry.addr;
				tag_op[exp_cmd.tag]     = exp_cmd.opcode;
				tag_cu[exp_cmd.tag]     = entry.cu_id;
				model_busy[exp_cmd.tag] = 1'b1;
				model_credits--;
				pending.push_back(exp_cmd.tag);
			end
			check_host_cmd(exp_cmd, host_cmd);

			// Client side of the response two cycles back
			exp_read  = '0;
			exp_write = '0;
			if (rsp_prev.valid) begin
				if (tag_op[rsp_prev.tag] == CMD_READ) begin
					exp_read.valid = 1'b1;
					exp_read.cu_id = tag_cu[rsp_prev.tag];
					exp_read.code  = rsp_prev.code;
				end else begin
					exp_write.valid = 1'b1;
					exp_write.cu_id = tag_cu[rsp_prev.tag];
					exp_write.code  = rsp_prev.code;
				end
				model_credits += int'(rsp_prev.credits);
				model_busy[rsp_prev.tag] = 1'b0;
			end
			check_client_rsp("read_rsp", exp_read, read_rsp);
			check_client_rsp("write_rsp", exp_write, write_rsp);
			rsp_prev = host_rsp;

			// Handshakes of the last rising edge
			if (rd_valid && rd_ready_seen) begin
				exp_rd.push_back(rd_cmd);
				accepted++;
			end
			if (wr_valid && wr_ready_seen) begin
				exp_wr.push_back(wr_cmd);
				accepted++;
			end
			check_ready("rd_ready", exp_rd.size() != DEPTH, rd_ready);
			check_ready("wr_ready", exp_wr.size() != DEPTH, wr_ready);

			// Host answers an owed tag at random
			host_rsp = '0;
			if (!withhold && pending.size() > 0 && lfsr_bits(1) == 64'd0) begin
				pick             = int'(lfsr_bits(4) % pending.size());
				host_rsp.valid   = 1'b1;
				host_rsp.tag     = pending[pick];
				host_rsp.code    = rsp_code_e'(2'(lfsr_bits(2) % 3));
				host_rsp.credits = `AFU_CREDIT_W'(1);
				pending.delete(pick);
			end

			// New client command unless the last one is still held
			if (!rd_valid || rd_ready_seen) begin
				rd_valid     = flood || (traffic_on && lfsr_bits(1) == 64'd1);
				rd_cmd.cu_id = `AFU_CU_W'(lfsr_bits(`AFU_CU_W));
				rd_cmd.addr  = lfsr_bits(`AFU_ADDR_W);
			end
			if (!wr_valid || wr_ready_seen) begin
				wr_valid     = flood || (traffic_on && lfsr_bits(1) == 64'd1);
				wr_cmd.cu_id = `AFU_CU_W'(lfsr_bits(`AFU_CU_W));
				wr_cmd.addr  = lfsr_bits(`AFU_ADDR_W);
			end
			rd_ready_seen = rd_ready;
			wr_ready_seen = wr_ready;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sequencer and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		@(posedge rst_n);
		@(posedge clock);
		running = 1'b1;
		// Quiet window right after reset
		repeat (8) @(posedge clock);
		traffic_on = 1'b1;
		while (accepted < N_RANDOM) begin
			@(posedge clock);
		end
		traffic_on = 1'b0;
		wait_drained();

		// Host silent, both clients push every cycle
		withhold = 1'b1;
		flood    = 1'b1;
		while (rd_ready_seen || wr_ready_seen) begin
			@(posedge clock);
		end
		repeat (6) @(posedge clock);
		if (pending.size() != `AFU_INIT_CREDITS || exp_rd.size() != DEPTH ||
				exp_wr.size() != DEPTH) begin
			stop_on_error($sformatf("stall state wrong at %0t: %0d outstanding, %0d %0d queued",
				$time, pending.size(), exp_rd.size(), exp_wr.size()));
		end
		flood    = 1'b0;
		withhold = 1'b0;
		wait_drained();
		$display("TEST RESULT: PASS");
		$finish;
	end

	initial begin
		repeat (N_CMDS * 40 + 200) @(posedge clock);
		stop_on_error("watchdog expired, the run hung before all commands completed");
	end

endmodule

// File: files.f
+incdir+include
hdl/afu_pkg.sv
hdl/cmd_queue.sv
hdl/cmd_issue.sv
hdl/afu_control.sv
sim/afu_clock_gen.sv
sim/afu_control_properties.sv
sim/afu_control_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := afu_control_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := TEST RESULT: FAIL
PASS_MSG  := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and scan $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
